// File: tb/issue_stimulus.txt
# R ready_mask bypass_mask | E pc issue order | P a b issue together | S a b never together | Q full
# C vld stall flush hold  pc1 cls ra1 ra2 rdst rw  pc0 cls ra1 ra2 rdst rw  (cls 0 alu .. 11 eret)
R ffffffff 0000aaaa
E 100
E 104
E 108
E 10c
E 110
E 114
E 118
E 11c
E 120
E 124
E 128
E 12c
E 130
E 134
E 138
E 13c
E 140
E 144
E 148
E 14c
E 150
E 154
E 300
E 304
P 100 104
P 130 134
P 148 14c
P 300 304
S 108 10c
S 110 114
S 118 11c
S 120 124
S 128 12c
S 138 13c
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 0  100 0 2 3 1 1  104 0 5 6 4 1
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 0  108 0 2 3 7 1  10c 0 7 9 8 1
C 11 0 0 0  110 1 2 3 0 0  114 1 4 5 0 0
C 11 0 0 0  118 6 10 0 0 0  11c 4 0 0 11 1
C 11 0 0 0  120 9 12 0 0 0  124 9 13 0 0 0
C 11 0 0 0  128 10 0 0 0 0  12c 0 14 15 16 1
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 0  130 8 0 0 17 1  134 9 18 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 0  138 0 19 20 21 1  13c 2 21 22 0 0
C 11 0 0 0  140 0 23 24 25 1  144 0 26 27 28 1
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 0  148 3 0 0 31 1  14c 0 29 30 1 1
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 0  150 0 1 2 3 1  154 0 4 5 6 1
C 00 1 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 1 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 11 0 0 1  200 0 1 2 3 1  204 0 4 5 6 1
C 11 0 0 1  208 0 1 2 3 1  20c 0 4 5 6 1
C 11 0 0 1  210 0 1 2 3 1  214 0 4 5 6 1
C 11 0 0 1  218 0 1 2 3 1  21c 0 4 5 6 1
C 11 0 0 1  220 0 1 2 3 1  224 0 4 5 6 1
C 11 0 0 1  228 0 1 2 3 1  22c 0 4 5 6 1
C 11 0 0 1  230 0 1 2 3 1  234 0 4 5 6 1
C 11 0 0 1  238 0 1 2 3 1  23c 0 4 5 6 1
C 11 0 0 1  240 0 1 2 3 1  244 0 4 5 6 1
C 11 0 0 1  248 0 1 2 3 1  24c 0 4 5 6 1
C 11 0 0 1  250 0 1 2 3 1  254 0 4 5 6 1
C 11 0 0 1  258 0 1 2 3 1  25c 0 4 5 6 1
C 11 0 0 1  260 0 1 2 3 1  264 0 4 5 6 1
C 11 0 0 1  268 0 1 2 3 1  26c 0 4 5 6 1
C 11 0 0 1  270 0 1 2 3 1  274 0 4 5 6 1
C 00 0 0 1  0 0 0 0 0 0  0 0 0 0 0 0
Q 1
C 00 0 1 1  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
Q 0
C 11 0 0 0  300 0 8 9 10 1  304 0 11 12 13 1
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0
C 00 0 0 0  0 0 0 0 0 0  0 0 0 0 0 0

// File: files.f
+incdir+rtl
rtl/issue_pkg.sv
rtl/issue_bank.sv
rtl/issue_queue_ctrl.sv
rtl/dual_issue_select.sv
rtl/issue_stage.sv
tb/issue_sva.sv
tb/issue_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module issue_tb -f files.f -o issue_sim \
    && ./obj_dir/issue_sim > sim.log 2>&1 \
    || echo "build or simulation error" >> sim.log

cat sim.log

grep -qx "Test passed" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }

// File: tb/issue_tb.sv
`timescale 1ns/100ps
`include "issue_config.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int TIMEOUT = 200;
    localparam int MAX_LAT = 40;

    logic                          clk;
    logic                          rst_n;
    logic                          stall;
    logic                          flush;
    logic                          hold;
    logic [1:0]                    dec_valid;
    queue_entry_t [1:0]            dec_entry;
    logic [1:0][`REG_ADDR_W-1:0]   cand_ra1;
    logic [1:0][`REG_ADDR_W-1:0]   cand_ra2;
    logic [1:0]                    op1_ready;
    logic [1:0]                    op2_ready;
    logic [1:0]                    op1_bypass;
    logic [1:0]                    op2_bypass;
    logic [1:0][`DATA_W-1:0]       op1_bypass_data;
    logic [1:0][`DATA_W-1:0]       op2_bypass_data;
    logic [1:0][`DATA_W-1:0]       rf_data1;
    logic [1:0][`DATA_W-1:0]       rf_data2;
    logic [1:0]                    issue_valid;
    issued_t [1:0]                 issue_rec;
    logic                          full;

    // scoreboard tables, bit n for register n
    logic [31:0] ready_tab;
    logic [31:0] bypass_tab;

    int           cyc;
    int           err_cnt [1:6];
    string        test_name [1:6];
    int           exp_order [$];
    int           exp_ptr;
    int           first_idx;
    int           pair_a [$];
    int           pair_b [$];
    int           split_a [$];
    int           split_b [$];
    int           push_cyc [int];
    int           issue_cyc [int];
    queue_entry_t sent [int];
    logic         flushed_idle;

    issue_stage issue_stage_i (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // scoreboard answers in the same cycle
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            op1_ready[i]       = ~hold & ready_tab[cand_ra1[i]];
            op2_ready[i]       = ~hold & ready_tab[cand_ra2[i]];
            op1_bypass[i]      = bypass_tab[cand_ra1[i]];
            op2_bypass[i]      = bypass_tab[cand_ra2[i]];
            op1_bypass_data[i] = 32'h1000 + 32'(cand_ra1[i]);
            op2_bypass_data[i] = 32'h1000 + 32'(cand_ra2[i]);
            rf_data1[i]        = 32'(cand_ra1[i]) * 32'd3;
            rf_data2[i]        = 32'(cand_ra2[i]) * 32'd3;
        end
    end

    task automatic check_val(input int t, input string name,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt[t]++;
        end
    endtask

    task automatic check_true(input int t, input logic cond, input string msg);
        assert (cond) else begin
            $display("ERROR t=%0t %s", $time, msg);
            err_cnt[t]++;
        end
    endtask

    // operand value the scoreboard model hands out
    function automatic logic [31:0] expected_operand(input logic [`REG_ADDR_W-1:0] ra);
        if (bypass_tab[ra]) begin
            return 32'h1000 + 32'(ra);
        end
        return 32'(ra) * 32'd3;
    endfunction

    function automatic queue_entry_t make_entry(input int v, input int pc, input int cls,
                                                input int a1, input int a2, input int d,
                                                input int w);
        queue_entry_t e;
        e.valid    = v[0];
        e.pc       = 32'(pc);
        e.imm      = 32'(pc) + 32'h10;
        e.ra1      = a1[`REG_ADDR_W-1:0];
        e.ra2      = a2[`REG_ADDR_W-1:0];
        e.rdst     = d[`REG_ADDR_W-1:0];
        e.regwrite = w[0];
        e.op_class = instr_class_t'(cls[3:0]);
        return e;
    endfunction

    // order, latency, fields and operand values of one issued slot
    task automatic check_slot(input int s);
        issued_t      r;
        queue_entry_t e;
        int           pc;
        r  = issue_rec[s];
        pc = int'(r.pc);
        if (exp_ptr < exp_order.size()) begin
            check_val(2, $sformatf("issue_rec[%0d].pc", s), 32'(exp_order[exp_ptr]), r.pc);
        end else begin
            check_true(2, 1'b0, $sformatf("pc %h issued beyond the expected list", pc));
        end
        exp_ptr++;
        check_true(2, !issue_cyc.exists(pc), $sformatf("pc %h issued twice", pc));
        issue_cyc[pc] = cyc;
        if (push_cyc.exists(pc)) begin
            check_true(2, (cyc - push_cyc[pc]) <= MAX_LAT,
                       $sformatf("pc %h waited too long in the queue", pc));
        end
        if (sent.exists(pc)) begin
            e = sent[pc];
            check_val(2, $sformatf("issue_rec[%0d].valid", s), 32'd1, 32'(r.valid));
            check_val(2, $sformatf("issue_rec[%0d].imm", s), e.imm, r.imm);
            check_val(2, $sformatf("issue_rec[%0d].ra1", s), 32'(e.ra1), 32'(r.ra1));
            check_val(2, $sformatf("issue_rec[%0d].ra2", s), 32'(e.ra2), 32'(r.ra2));
            check_val(2, $sformatf("issue_rec[%0d].rdst", s), 32'(e.rdst), 32'(r.rdst));
            check_val(2, $sformatf("issue_rec[%0d].regwrite", s), 32'(e.regwrite),
                      32'(r.regwrite));
            check_val(2, $sformatf("issue_rec[%0d].op_class", s), 32'(e.op_class),
                      32'(r.op_class));
            check_val(5, $sformatf("issue_rec[%0d].rd1", s), expected_operand(e.ra1), r.rd1);
            check_val(5, $sformatf("issue_rec[%0d].rd2", s), expected_operand(e.ra2), r.rd2);
        end else begin
            check_true(2, 1'b0, $sformatf("pc %h was never pushed", pc));
        end
    endtask

    // outputs sampled mid cycle
    // a pop only happens when the next edge has neither stall nor flush
    always @(negedge clk) begin
        if (rst_n && !stall && !flush) begin
            first_idx = exp_ptr;
            if (issue_valid[1]) begin
                check_slot(1);
            end
            if (issue_valid[0]) begin
                check_slot(0);
            end
            if (issue_valid[1] && (issue_rec[1].op_class inside {ic_branch, ic_jump})) begin
                check_val(4, "issue_valid[0]", 32'd1, 32'(issue_valid[0]));
                check_val(4, "issue_rec[0].is_slot", 32'd1, 32'(issue_rec[0].is_slot));
                // delay slot is the next pc in file order
                if (first_idx + 1 < exp_order.size()) begin
                    check_val(4, "issue_rec[0].pc", 32'(exp_order[first_idx + 1]),
                              issue_rec[0].pc);
                end
            end else if (issue_valid[0]) begin
                check_val(4, "issue_rec[0].is_slot", 32'd0, 32'(issue_rec[0].is_slot));
            end
            if (issue_valid[0]) begin
                check_true(4, !(issue_rec[0].op_class inside {ic_branch, ic_jump}),
                           "branch or jump issued in slot 2");
            end
        end
        if (rst_n && flushed_idle) begin
            check_val(6, "issue_valid", 32'd0, 32'(issue_valid));
        end
    end

    // pair timing from the recorded cycles
    task automatic check_pairs();
        int a;
        int b;
        for (int i = 0; i < pair_a.size(); i++) begin
            a = pair_a[i];
            b = pair_b[i];
            if (issue_cyc.exists(a) && issue_cyc.exists(b) && push_cyc.exists(a)) begin
                check_val(3, $sformatf("issue cycle of pc %h", a), 32'(push_cyc[a]),
                          32'(issue_cyc[a]));
                check_val(3, $sformatf("issue cycle of pc %h", b), 32'(issue_cyc[a]),
                          32'(issue_cyc[b]));
            end else begin
                check_true(3, 1'b0, $sformatf("pair %h %h did not issue", a, b));
            end
        end
        for (int i = 0; i < split_a.size(); i++) begin
            a = split_a[i];
            b = split_b[i];
            if (issue_cyc.exists(a) && issue_cyc.exists(b)) begin
                check_true(3, issue_cyc[a] != issue_cyc[b],
                           $sformatf("pcs %h and %h issued in the same cycle", a, b));
            end else begin
                check_true(3, 1'b0, $sformatf("split pair %h %h did not issue", a, b));
            end
        end
    endtask

    // one command per line, see the stimulus file for the columns
    task automatic run_file(input int fd);
        string        line;
        string        kind;
        int           code;
        int           v, st, fl, hd, qf;
        int           p1, c1, a11, a12, d1, w1;
        int           p0, c0, a01, a02, d0, w0;
        queue_entry_t e1;
        queue_entry_t e0;
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "%s", kind) == 1) begin
                if (kind == "R") begin
                    code = $sscanf(line, "%s %h %h", kind, ready_tab, bypass_tab);
                end else if (kind == "E") begin
                    code = $sscanf(line, "%s %h", kind, p1);
                    exp_order.push_back(p1);
                end else if (kind == "P" || kind == "S") begin
                    code = $sscanf(line, "%s %h %h", kind, p1, p0);
                    if (kind == "P") begin
                        pair_a.push_back(p1);
                        pair_b.push_back(p0);
                    end else begin
                        split_a.push_back(p1);
                        split_b.push_back(p0);
                    end
                end else if (kind == "Q") begin
                    code = $sscanf(line, "%s %d", kind, qf);
                    @(negedge clk);
                    check_val(6, "full", 32'(qf), 32'(full));
                end else if (kind == "C") begin
                    code = $sscanf(line, "%s %b %d %d %d %h %d %d %d %d %d %h %d %d %d %d %d",
                                   kind, v, st, fl, hd, p1, c1, a11, a12, d1, w1,
                                   p0, c0, a01, a02, d0, w0);
                    e1 = make_entry(v >> 1, p1, c1, a11, a12, d1, w1);
                    e0 = make_entry(v, p0, c0, a01, a02, d0, w0);
                    @(posedge clk);
                    cyc = cyc + 1;
                    dec_valid    <= v[1:0];
                    dec_entry[1] <= e1;
                    dec_entry[0] <= e0;
                    stall        <= st[0];
                    flush        <= fl[0];
                    hold         <= hd[0];
                    // the entry lands at the next edge
                    if (v[1]) begin
                        push_cyc[p1] = cyc + 1;
                        sent[p1]     = e1;
                    end
                    if (v[0]) begin
                        push_cyc[p0] = cyc + 1;
                        sent[p0]     = e0;
                    end
                    if (fl != 0) begin
                        flushed_idle = 1'b1;
                    end else if (v != 0) begin
                        flushed_idle = 1'b0;
                    end
                end
            end
        end
    endtask

    initial begin
        int fd;
        int wait_cnt;
        int total;
        int failed;
        test_name[1] = "reset values";
        test_name[2] = "issue order";
        test_name[3] = "pairing";
        test_name[4] = "delay slot";
        test_name[5] = "operand select";
        test_name[6] = "full and flush";
        for (int t = 1; t <= 6; t++) begin
            err_cnt[t] = 0;
        end
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        hold         = 1'b0;
        dec_valid    = 2'b00;
        dec_entry    = '0;
        ready_tab    = 32'hffff_ffff;
        bypass_tab   = 32'h0;
        cyc          = 0;
        exp_ptr      = 0;
        first_idx    = 0;
        flushed_idle = 1'b0;
        wait_cnt     = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_val(1, "issue_valid", 32'd0, 32'(issue_valid));
        check_val(1, "full", 32'd0, 32'(full));

        fd = $fopen("tb/issue_stimulus.txt", "r");
        if (fd == 0) begin
            check_true(2, 1'b0, "stimulus file could not be opened");
        end else begin
            run_file(fd);
            $fclose(fd);
        end

        // back to idle, then let the queue drain
        @(posedge clk);
        cyc = cyc + 1;
        dec_valid <= 2'b00;
        stall     <= 1'b0;
        flush     <= 1'b0;
        hold      <= 1'b0;
        while (exp_ptr < exp_order.size() && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            cyc = cyc + 1;
            wait_cnt++;
        end
        check_true(2, exp_ptr >= exp_order.size(),
                   "timeout while waiting for the remaining instructions to issue");
        @(negedge clk);
        check_pairs();

        total  = 0;
        failed = 0;
        for (int t = 1; t <= 6; t++) begin
            $display("test %0d %s: %s, %0d errors", t, test_name[t],
                     (err_cnt[t] == 0) ? "ok" : "FAILED", err_cnt[t]);
            total += err_cnt[t];
            if (err_cnt[t] != 0) begin
                failed++;
            end
        end
        $display("summary: 6 tests, %0d passed, %0d failed, %0d errors", 6 - failed, failed,
                 total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/issue_sva.sv
`timescale 1ns/100ps

module issue_sva (
    input logic       clk,
    input logic       rst_n,
    input logic       stall,
    input logic       full,
    input logic [1:0] dec_valid,
    input logic [1:0] issue_valid
);

    // producer holds back while the queue is full or stalled
    property no_push_when_blocked;
        @(posedge clk) disable iff (!rst_n)
            (|dec_valid) |-> !(full || stall);
    endproperty

    // slot 2 never issues without slot 1
    property slot2_needs_slot1;
        @(posedge clk) disable iff (!rst_n)
            issue_valid[0] |-> issue_valid[1];
    endproperty

    // empty queue right after reset
    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> (issue_valid == 2'b00);
    endproperty

    push_blocked_a: assert property (no_push_when_blocked)
        else $error("valid instruction presented while full or stall is high");

    slot_order_a: assert property (slot2_needs_slot1)
        else $error("slot 2 issued without slot 1");

    reset_quiet_a: assert property (quiet_after_reset)
        else $error("issue_valid set in the cycle after reset");

endmodule

bind issue_stage issue_sva issue_sva_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .full        (full),
    .dec_valid   (dec_valid),
    .issue_valid (issue_valid)
);

// File: rtl/issue_stage.sv
`timescale 1ns/100ps
`include "issue_config.svh"

module issue_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          flush,
    // decode side
    input  logic [1:0]                    dec_valid,
    input  issue_pkg::queue_entry_t [1:0] dec_entry,
    // scoreboard side
    output logic [1:0][`REG_ADDR_W-1:0]   cand_ra1,
    output logic [1:0][`REG_ADDR_W-1:0]   cand_ra2,
    input  logic [1:0]                    op1_ready,
    input  logic [1:0]                    op2_ready,
    input  logic [1:0]                    op1_bypass,
    input  logic [1:0]                    op2_bypass,
    input  logic [1:0][`DATA_W-1:0]       op1_bypass_data,
    input  logic [1:0][`DATA_W-1:0]       op2_bypass_data,
    input  logic [1:0][`DATA_W-1:0]       rf_data1,
    input  logic [1:0][`DATA_W-1:0]       rf_data2,
    // execute side
    output logic [1:0]                    issue_valid,
    output issue_pkg::issued_t [1:0]      issue_rec,
    output logic                          full
);
    import issue_pkg::*;

    // two oldest entries, index 1 first
    queue_entry_t [1:0] cand;
    // entries leaving at the next edge
    logic [1:0]         pop_count;

    issue_queue_ctrl issue_queue_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .dec_valid (dec_valid),
        .dec_entry (dec_entry),
        .pop_count (pop_count),
        .cand      (cand),
        .full      (full)
    );

    dual_issue_select dual_issue_select_i (
        .cand            (cand),
        .op1_ready       (op1_ready),
        .op2_ready       (op2_ready),
        .op1_bypass      (op1_bypass),
        .op2_bypass      (op2_bypass),
        .op1_bypass_data (op1_bypass_data),
        .op2_bypass_data (op2_bypass_data),
        .rf_data1        (rf_data1),
        .rf_data2        (rf_data2),
        .cand_ra1        (cand_ra1),
        .cand_ra2        (cand_ra2),
        .issue_valid     (issue_valid),
        .issue_rec       (issue_rec),
        .pop_count       (pop_count)
    );

endmodule

// File: rtl/dual_issue_select.sv
`timescale 1ns/100ps
`include "issue_config.svh"

module dual_issue_select (
    input  issue_pkg::queue_entry_t [1:0]     cand,
    input  logic [1:0]                        op1_ready,
    input  logic [1:0]                        op2_ready,
    input  logic [1:0]                        op1_bypass,
    input  logic [1:0]                        op2_bypass,
    input  logic [1:0][`DATA_W-1:0]           op1_bypass_data,
    input  logic [1:0][`DATA_W-1:0]           op2_bypass_data,
    input  logic [1:0][`DATA_W-1:0]           rf_data1,
    input  logic [1:0][`DATA_W-1:0]           rf_data2,
    output logic [1:0][`REG_ADDR_W-1:0]       cand_ra1,
    output logic [1:0][`REG_ADDR_W-1:0]       cand_ra2,
    output logic [1:0]                        issue_valid,
    output issue_pkg::issued_t [1:0]          issue_rec,
    output logic [1:0]                        pop_count
);
    import issue_pkg::*;

    queue_entry_t             c1;
    queue_entry_t             c2;
    logic                     c1_ready;
    logic                     c2_ready;
    logic                     c1_ctrl;
    logic                     c2_ctrl;
    logic                     dep_hit;
    logic                     muldiv_hit;
    logic                     hilo_hit;
    logic                     cp0_hit;
    logic                     c1_trap;
    logic                     pair_ok;
    logic                     en1;
    logic                     en2;
    logic [1:0][`DATA_W-1:0]  src1;
    logic [1:0][`DATA_W-1:0]  src2;

    // copy an entry into an issued record
    function automatic issued_t build_rec(
        input queue_entry_t       e,
        input logic [`DATA_W-1:0] d1,
        input logic [`DATA_W-1:0] d2,
        input logic               slot
    );
        issued_t r;
        r.valid    = e.valid;
        r.pc       = e.pc;
        r.imm      = e.imm;
        r.ra1      = e.ra1;
        r.ra2      = e.ra2;
        r.rdst     = e.rdst;
        r.regwrite = e.regwrite;
        r.op_class = e.op_class;
        r.rd1      = d1;
        r.rd2      = d2;
        r.is_slot  = slot;
        return r;
    endfunction

    // index 1 is the older candidate
    assign c1 = cand[1];
    assign c2 = cand[0];

    // source registers go out to the scoreboard
    assign cand_ra1[1] = c1.ra1;
    assign cand_ra2[1] = c1.ra2;
    assign cand_ra1[0] = c2.ra1;
    assign cand_ra2[0] = c2.ra2;

    assign c1_ready = op1_ready[1] & op2_ready[1];
    assign c2_ready = op1_ready[0] & op2_ready[0];

    assign c1_ctrl = c1.op_class inside {ic_branch, ic_jump};
    assign c2_ctrl = c2.op_class inside {ic_branch, ic_jump};

    // raw hazard on candidate 1's result
    // delay slot reads the old value, so no hazard behind a branch
    assign dep_hit = c1.regwrite & ~c1_ctrl &
                     ((c1.rdst == c2.ra1) | (c1.rdst == c2.ra2));

    // single multiply/divide unit
    assign muldiv_hit = (c1.op_class == ic_mul_div) & (c2.op_class == ic_mul_div);

    // hi/lo written then read
    assign hilo_hit = ((c1.op_class == ic_mthi) & (c2.op_class == ic_mfhi)) |
                      ((c1.op_class == ic_mtlo) & (c2.op_class == ic_mflo));

    // cp0 has one port
    // mfc0 ahead of mtc0 is the only legal pair
    assign cp0_hit = ((c1.op_class == ic_mtc0) & (c2.op_class == ic_mtc0)) |
                     ((c1.op_class == ic_mfc0) & (c2.op_class == ic_mfc0)) |
                     ((c1.op_class == ic_mtc0) & (c2.op_class == ic_mfc0));

    // traps leave slot 2 empty
    assign c1_trap = (c1.op_class == ic_exception) | (c1.op_class == ic_eret);

    assign pair_ok = ~dep_hit & ~muldiv_hit & ~hilo_hit & ~cp0_hit & ~c2_ctrl & ~c1_trap;

    // branch waits until its delay slot can go along
    // a control transfer in the delay slot holds the branch back
    assign en1 = c1.valid & c1_ready & (~c1_ctrl | (c2.valid & c2_ready & pair_ok));
    assign en2 = en1 & c2.valid & c2_ready & pair_ok;

    assign issue_valid = {en1, en2};
    assign pop_count   = {1'b0, en1} + {1'b0, en2};

    // operand muxes
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            src1[i] = op1_bypass[i] ? op1_bypass_data[i] : rf_data1[i];
            src2[i] = op2_bypass[i] ? op2_bypass_data[i] : rf_data2[i];
        end
    end

    // records are zero when the slot does not issue
    always_comb begin
        issue_rec = '0;
        if (en1) begin
            issue_rec[1] = build_rec(c1, src1[1], src2[1], 1'b0);
        end
        if (en2) begin
            issue_rec[0] = build_rec(c2, src1[0], src2[0], c1_ctrl);
        end
    end

endmodule

// File: rtl/issue_queue_ctrl.sv
`timescale 1ns/100ps
`include "issue_config.svh"

module issue_queue_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [1:0]                    dec_valid,
    input  issue_pkg::queue_entry_t [1:0] dec_entry,
    input  logic [1:0]                    pop_count,
    output issue_pkg::queue_entry_t [1:0] cand,
    output logic                          full
);
    import issue_pkg::*;

    bank_idx_t    head_even;
    bank_idx_t    head_odd;
    bank_idx_t    tail_even;
    bank_idx_t    tail_odd;
    logic         any_valid;
    logic         both_valid;
    logic         odd_first;
    logic         write_ok;
    logic         even_we;
    logic         odd_we;
    queue_entry_t first_entry;
    queue_entry_t even_wdata;
    queue_entry_t odd_wdata;
    queue_entry_t even_rdata;
    queue_entry_t odd_rdata;
    logic         odd_older;
    logic         even_empty;
    logic         odd_empty;
    logic         pop_even;
    logic         pop_odd;

    // pointers count downwards and wrap at zero
    function automatic bank_idx_t next_idx(input bank_idx_t idx);
        return (idx == '0) ? bank_idx_t'(`ISSUE_DEPTH - 1) : idx - 1'b1;
    endfunction

    // write steering
    // index 1 is older, a lone valid may sit in either lane
    assign any_valid   = |dec_valid;
    assign both_valid  = &dec_valid;
    assign first_entry = dec_valid[1] ? dec_entry[1] : dec_entry[0];

    // equal tails mean odd takes the next arrival
    assign odd_first = (tail_odd == tail_even);
    assign write_ok  = ~stall & ~flush;

    assign odd_we     = write_ok & (odd_first ? any_valid : both_valid);
    assign even_we    = write_ok & (odd_first ? both_valid : any_valid);
    assign odd_wdata  = odd_first ? first_entry : dec_entry[0];
    assign even_wdata = odd_first ? dec_entry[0] : first_entry;

    issue_bank even_bank (
        .clk   (clk),
        .we    (even_we),
        .waddr (tail_even),
        .wdata (even_wdata),
        .raddr (head_even),
        .rdata (even_rdata)
    );

    issue_bank odd_bank (
        .clk   (clk),
        .we    (odd_we),
        .waddr (tail_odd),
        .wdata (odd_wdata),
        .raddr (head_odd),
        .rdata (odd_rdata)
    );

    // candidate ordering
    assign odd_older  = (head_odd == head_even);
    assign even_empty = (head_even == tail_even);
    assign odd_empty  = (head_odd == tail_odd);

    always_comb begin
        if (odd_older) begin
            cand[1]       = odd_rdata;
            cand[1].valid = odd_rdata.valid & ~odd_empty;
            cand[0]       = even_rdata;
            cand[0].valid = even_rdata.valid & ~even_empty;
        end else begin
            cand[1]       = even_rdata;
            cand[1].valid = even_rdata.valid & ~even_empty;
            cand[0]       = odd_rdata;
            cand[0].valid = odd_rdata.valid & ~odd_empty;
        end
    end

    // one pop takes candidate 1's bank, two take both
    assign pop_odd  = (pop_count == 2'd2) | ((pop_count == 2'd1) & odd_older);
    assign pop_even = (pop_count == 2'd2) | ((pop_count == 2'd1) & ~odd_older);

    // tails move on every accepted write
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            tail_even <= '0;
            tail_odd  <= '0;
        end else begin
            if (odd_we) begin
                tail_odd <= next_idx(tail_odd);
            end
            if (even_we) begin
                tail_even <= next_idx(tail_even);
            end
        end
    end

    // heads freeze under stall
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head_even <= '0;
            head_odd  <= '0;
        end else if (!stall) begin
            if (pop_odd) begin
                head_odd <= next_idx(head_odd);
            end
            if (pop_even) begin
                head_even <= next_idx(head_even);
            end
        end
    end

    // no room for one more in either bank
    assign full = (next_idx(tail_even) == head_even) | (next_idx(tail_odd) == head_odd);

endmodule

// File: rtl/issue_bank.sv
`timescale 1ns/100ps
`include "issue_config.svh"

module issue_bank (
    input  logic                    clk,
    input  logic                    we,
    input  issue_pkg::bank_idx_t    waddr,
    input  issue_pkg::queue_entry_t wdata,
    input  issue_pkg::bank_idx_t    raddr,
    output issue_pkg::queue_entry_t rdata
);
    import issue_pkg::*;

    // storage for one bank
    queue_entry_t mem [`ISSUE_DEPTH];

    // write at the edge
    // tail pointer selects the slot
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // asynchronous read of the head slot
    // an entry written at edge N is visible right after it
    assign rdata = mem[raddr];

endmodule

// File: rtl/issue_pkg.sv
`include "issue_config.svh"

package issue_pkg;

    // coarse instruction classes
    // only what the pairing rules need to see
    typedef enum logic [3:0] {
        ic_alu,
        ic_mul_div,
        ic_branch,
        ic_jump,
        ic_mfhi,
        ic_mflo,
        ic_mthi,
        ic_mtlo,
        ic_mfc0,
        ic_mtc0,
        ic_exception,
        ic_eret
    } instr_class_t;

    // decoded instruction as held in a bank
    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     imm;
        logic [`REG_ADDR_W-1:0] ra1;
        logic [`REG_ADDR_W-1:0] ra2;
        logic [`REG_ADDR_W-1:0] rdst;
        logic                   regwrite;
        instr_class_t           op_class;
    } queue_entry_t;

    // record sent to execute
    // same fields plus operand values and the delay slot mark
    typedef struct packed {
        logic                   valid;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     imm;
        logic [`REG_ADDR_W-1:0] ra1;
        logic [`REG_ADDR_W-1:0] ra2;
        logic [`REG_ADDR_W-1:0] rdst;
        logic                   regwrite;
        instr_class_t           op_class;
        logic [`DATA_W-1:0]     rd1;
        logic [`DATA_W-1:0]     rd2;
        logic                   is_slot;
    } issued_t;

    // pointer into one bank
    typedef logic [$clog2(`ISSUE_DEPTH)-1:0] bank_idx_t;

endpackage

// File: rtl/issue_config.svh
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// sizing of the issue stage

// entries per bank
// one slot stays unused so that full and empty differ
`define ISSUE_DEPTH 16

// register number width
`define REG_ADDR_W 5

// operand, pc and immediate width
`define DATA_W 32

`endif
